//--- list.f
uart_pkg.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
uart_regs.sv
uart_top.sv
uart_checker.sv
uart_asserts.sv
tb_uart.sv

//--- tb_uart.sv
`timescale 1ns/1ns
`default_nettype none

module tb_uart
    import uart_pkg::*;
();

    localparam int BIT_CLKS    = 8;
    localparam int NROWS       = 7;
    localparam int POLL_LIMIT  = 1000;
    localparam int WATCHDOG_NS = (NROWS + FIFO_DEPTH + 9) * MAX_FRAME_BITS * BIT_CLKS * 10 * 4;

    logic        clk;
    logic        rst_n;
    logic        bus_write;
    logic        bus_read;
    addr_t       addr_word;
    word_t       wdata;
    word_t       rdata;
    logic        tx;
    logic        rx;
    logic        rs485_de;
    logic        rs485_re;
    logic        irq;
    logic        loop_sel;
    logic        bang_line;
    int          timeouts;
    logic [31:0] rng;
    data_t       sent[$];

    // Stimulus table; mode is {two_stop, parity_odd, parity_en}.
    string      row_name[NROWS] = '{"8n1", "8e1", "8o1", "8n2", "8o2", "par_flip", "stop_bad"};
    logic [2:0] row_mode[NROWS] = '{3'b000, 3'b001, 3'b011, 3'b100, 3'b111, 3'b001, 3'b100};
    data_t      row_data[NROWS] = '{8'h55, 8'ha3, 8'h3c, 8'hf0, 8'h81, 8'h5a, 8'hc6};
    logic       row_flip[NROWS] = '{0, 0, 0, 0, 0, 1, 0};
    logic       row_bad[NROWS]  = '{0, 0, 0, 0, 0, 0, 1};
    word_t      row_stat[NROWS] = '{32'h03, 32'h03, 32'h03, 32'h03, 32'h03, 32'h22, 32'h06};

    assign rx = loop_sel ? tx : bang_line;

    uart_top i_uart_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_write (bus_write),
        .bus_read  (bus_read),
        .addr_word (addr_word),
        .wdata     (wdata),
        .rdata     (rdata),
        .tx        (tx),
        .rx        (rx),
        .rs485_de  (rs485_de),
        .rs485_re  (rs485_re),
        .irq       (irq)
    );

    uart_checker #(.BIT_CLKS(BIT_CLKS)) i_chk (
        .clk   (clk),
        .rst_n (rst_n),
        .tx    (tx)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic bus_wr(input addr_t a, input word_t d);
        @(posedge clk);
        bus_write <= 1'b1;
        addr_word <= a;
        wdata     <= d;
        @(posedge clk);
        bus_write <= 1'b0;
    endtask

    task automatic bus_rd(input addr_t a, output word_t d);
        @(posedge clk);
        bus_read  <= 1'b1;
        addr_word <= a;
        @(negedge clk);
        d = rdata;
        @(posedge clk);
        bus_read <= 1'b0;
    endtask

    task automatic check_reg(input string name, input addr_t a, input word_t exp,
                             input word_t mask);
        word_t v;
        bus_rd(a, v);
        i_chk.compare(name, exp, v & mask);
    endtask

    task automatic check_pins(input string name, input logic de, input logic re);
        @(negedge clk);
        i_chk.compare(name, {30'd0, de, re}, {30'd0, rs485_de, rs485_re});
    endtask

    task automatic wait_status(input string name, input int pos, input logic level);
        word_t v;
        int    n;
        n = 0;
        bus_rd(ADDR_STATUS, v);
        while (v[pos] !== level && n < POLL_LIMIT) begin
            bus_rd(ADDR_STATUS, v);
            n++;
        end
        if (v[pos] !== level) begin
            timeouts++;
            $display("Timeout in %s: status bit %0d never became %0b.", name, pos, level);
        end
    endtask

    task automatic wait_irq(input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (irq !== 1'b1 && n < 2 * POLL_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (irq !== 1'b1) begin
            timeouts++;
            $display("Timeout in %s: irq never went high.", name);
        end
    endtask

    task automatic bang_frame(input data_t d, input logic [2:0] mode, input logic flip,
                              input logic bad_stop);
        logic [11:0] f;
        int          n;
        n    = 10 + mode[0] + mode[2];
        f    = '1;
        f[0] = 1'b0;
        f[8:1] = d;
        if (mode[0]) begin
            f[9] = (^d) ^ mode[1] ^ flip;
        end
        f[9 + mode[0]] = !bad_stop;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            bang_line <= f[i];
            repeat (BIT_CLKS - 1) @(posedge clk);
        end
    endtask

    initial begin
        #WATCHDOG_NS;
        $display("Watchdog expired before the tests finished.");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        word_t v;
        data_t b;
        clk       = 1'b0;
        rst_n     = 1'b0;
        bus_write = 1'b0;
        bus_read  = 1'b0;
        addr_word = '0;
        wdata     = '0;
        loop_sel  = 1'b1;
        bang_line = 1'b1;
        timeouts  = 0;
        rng       = 32'd2187;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        check_reg("reset ctrl", ADDR_CTRL, 32'd1, '1);
        check_reg("reset baud", ADDR_BAUD, 32'd50_000_000 / 32'd115_200, '1);
        check_reg("reset rs485", ADDR_RS485, 32'd1, '1);
        check_reg("reset status", ADDR_STATUS, 32'h02, '1);
        @(negedge clk);
        i_chk.compare("reset irq", 32'd0, {31'd0, irq});
        i_chk.compare("reset tx", 32'd1, {31'd0, tx});
        bus_wr(ADDR_BAUD, BIT_CLKS - 1);

        for (int r = 0; r < NROWS; r++) begin
            bus_wr(ADDR_CTRL, {28'd0, row_mode[r], 1'b1});
            if (row_flip[r] || row_bad[r]) begin
                @(posedge clk);
                loop_sel <= 1'b0;
                bang_frame(row_data[r], row_mode[r], row_flip[r], row_bad[r]);
                wait_status(row_name[r], row_flip[r] ? ST_PARITY_ERR : ST_FRAME_ERR, 1'b1);
                check_reg({row_name[r], " status"}, ADDR_STATUS, row_stat[r], '1);
                check_reg({row_name[r], " irq set"}, ADDR_IRQ_STATUS, 32'h4, 32'h5);
                bus_wr(ADDR_IRQ_STATUS, 32'h4);
                check_reg({row_name[r], " cleared"}, ADDR_STATUS, 32'h02, '1);
                check_reg({row_name[r], " irq clear"}, ADDR_IRQ_STATUS, 32'h0, 32'h4);
            end else begin
                @(posedge clk);
                loop_sel <= 1'b1;
                i_chk.expect_frame(row_name[r], row_data[r], row_mode[r]);
                bus_wr(ADDR_DATA, {24'd0, row_data[r]});
                wait_status(row_name[r], ST_RX_AVAIL, 1'b1);
                check_reg({row_name[r], " status"}, ADDR_STATUS, row_stat[r], '1);
                check_reg({row_name[r], " irq set"}, ADDR_IRQ_STATUS, 32'h1, 32'h1);
                check_reg({row_name[r], " rx data"}, ADDR_DATA, {24'd0, row_data[r]}, '1);
                check_reg({row_name[r], " irq clear"}, ADDR_IRQ_STATUS, 32'h0, 32'h1);
            end
        end

        // One byte more than the rx FIFO holds is looped back with no reads.
        @(posedge clk);
        loop_sel <= 1'b1;
        bus_wr(ADDR_CTRL, 32'd1);
        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            rng = xorshift(rng);
            b   = rng[7:0];
            sent.push_back(b);
            i_chk.expect_frame("overrun", b, 3'b000);
            bus_wr(ADDR_DATA, {24'd0, b});
        end
        wait_status("overrun", ST_OVERRUN, 1'b1);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            check_reg("overrun data", ADDR_DATA, {24'd0, sent[i]}, '1);
        end
        check_reg("overrun status", ADDR_STATUS, 32'h0a, '1);
        bus_wr(ADDR_IRQ_STATUS, 32'h7);

        // Interrupt with the mask at zero, then with only tx done enabled.
        bus_wr(ADDR_IRQ_EN, 32'h0);
        i_chk.expect_frame("irq_mask", 8'h12, 3'b000);
        bus_wr(ADDR_DATA, 32'h12);
        wait_status("irq_mask", ST_RX_AVAIL, 1'b1);
        check_reg("irq_mask tx_done", ADDR_IRQ_STATUS, 32'h2, 32'h2);
        @(negedge clk);
        i_chk.compare("irq_mask irq", 32'd0, {31'd0, irq});
        check_reg("irq_mask data", ADDR_DATA, 32'h12, '1);
        bus_wr(ADDR_IRQ_EN, 32'h2);
        i_chk.expect_frame("irq_done", 8'h34, 3'b000);
        i_chk.expect_frame("irq_done", 8'h56, 3'b000);
        bus_wr(ADDR_DATA, 32'h34);
        bus_wr(ADDR_DATA, 32'h56);
        @(negedge clk);
        i_chk.compare("irq_done early", 32'd0, {31'd0, irq});
        wait_irq("irq_done");
        check_reg("irq_done busy", ADDR_STATUS, 32'h0, 32'h10);
        bus_wr(ADDR_IRQ_STATUS, 32'h2);
        @(negedge clk);
        i_chk.compare("irq_done clear", 32'd0, {31'd0, irq});
        wait_status("irq_done", ST_RX_AVAIL, 1'b1);
        check_reg("irq_done data", ADDR_DATA, 32'h34, '1);
        wait_status("irq_done", ST_RX_AVAIL, 1'b1);
        check_reg("irq_done data", ADDR_DATA, 32'h56, '1);
        bus_wr(ADDR_IRQ_EN, 32'h0);

        // RS-485 auto mode follows the transmitter.
        i_chk.expect_frame("rs485_auto", 8'h9e, 3'b000);
        bus_wr(ADDR_DATA, 32'h9e);
        check_pins("rs485_auto on", 1'b1, 1'b0);
        wait_status("rs485_auto", ST_RX_AVAIL, 1'b1);
        check_pins("rs485_auto off", 1'b0, 1'b1);
        check_reg("rs485_auto data", ADDR_DATA, 32'h9e, '1);
        for (int i = 0; i < 16; i++) begin
            v = i;
            bus_wr(ADDR_RS485, {27'd0, v[3:0], 1'b0});
            check_pins("rs485_manual", v[2] ^ v[0], v[3] ^ v[1]);
        end
        bus_wr(ADDR_RS485, 32'd1);

        repeat (4) @(posedge clk);
        if (i_chk.pending() != 0) begin
            i_chk.report("Some expected tx frames never appeared on the line.");
        end
        $display("Checks done: %0d errors, %0d timeouts", i_chk.errors, timeouts);
        if (i_chk.errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- uart_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module uart_asserts
    import uart_pkg::*;
(
    input wire            clk,
    input wire            rst_n,
    input wire            tx,
    input wire tx_state_t tx_state,
    input wire            irq,
    input wire word_t     irq_en,
    input wire word_t     irq_status,
    input wire word_t     rs485_ctrl,
    input wire            rs485_de,
    input wire            rs485_re
);

    a_tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        (tx_state == TX_IDLE) |-> tx)
        else $error("tx low while the transmitter is idle");

    a_irq_masked: assert property (@(posedge clk) disable iff (!rst_n)
        ((irq_en & irq_status) == '0) |-> !irq)
        else $error("irq high with no enabled pending interrupt");

    // Plain auto mode keeps the receiver off whenever the driver is on.
    a_rs485_auto: assert property (@(posedge clk) disable iff (!rst_n)
        (rs485_ctrl[RS_AUTO] && !rs485_ctrl[RS_DE_INV] && !rs485_ctrl[RS_RE_INV])
        |-> (rs485_re == !rs485_de))
        else $error("rs485_re is not the inverse of rs485_de in auto mode");

endmodule

bind uart_top uart_asserts i_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .tx         (tx),
    .tx_state   (i_tx.state),
    .irq        (irq),
    .irq_en     (i_regs.irq_en),
    .irq_status (i_regs.irq_status),
    .rs485_ctrl (i_regs.rs485_ctrl),
    .rs485_de   (rs485_de),
    .rs485_re   (rs485_re)
);

`default_nettype wire

//--- uart_checker.sv
`timescale 1ns/1ns
`default_nettype none

module uart_checker
    import uart_pkg::*;
#(
    parameter int BIT_CLKS = 8
) (
    input wire clk,
    input wire rst_n,
    input wire tx
);

    int        errors;
    string     exp_name[$];
    data_t     exp_data[$];
    logic [2:0] exp_mode[$];

    initial begin
        errors = 0;
    end

    task automatic compare(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic report(input string what);
        errors++;
        $display("%s", what);
    endtask

    // Mode is {two_stop, parity_odd, parity_en}.
    task automatic expect_frame(input string name, input data_t data, input logic [2:0] mode);
        exp_name.push_back(name);
        exp_data.push_back(data);
        exp_mode.push_back(mode);
    endtask

    function automatic int pending();
        return exp_data.size();
    endfunction

    // Each frame is sampled in the middle of its bits, counted from the start edge.
    always begin : decode
        logic [11:0] bits;
        logic [2:0]  mode;
        data_t       data;
        string       name;
        logic        known;
        logic        stop2;
        int          n;
        @(negedge tx);
        if (rst_n) begin
            known = (exp_data.size() != 0);
            if (known) begin
                name = exp_name.pop_front();
                data = exp_data.pop_front();
                mode = exp_mode.pop_front();
            end else begin
                report("An unexpected frame appeared on the tx line.");
                mode = 3'b000;
            end
            n = 10 + mode[0] + mode[2];
            bits = '1;
            repeat (BIT_CLKS / 2) @(negedge clk);
            for (int i = 0; i < n; i++) begin
                if (i > 0) begin
                    repeat (BIT_CLKS) @(negedge clk);
                end
                bits[i] = tx;
            end
            if (known) begin
                compare({name, " start bit"}, 32'd0, {31'd0, bits[0]});
                compare({name, " tx data"}, {24'd0, data}, {24'd0, bits[8:1]});
                if (mode[0]) begin
                    compare({name, " parity bit"}, {31'd0, (^data) ^ mode[1]},
                            {31'd0, bits[9]});
                end
                stop2 = mode[2] ? bits[10 + mode[0]] : 1'b1;
                compare({name, " stop bits"}, 32'd3, {30'd0, bits[9 + mode[0]], stop2});
            end
        end
    end

endmodule

`default_nettype wire

//--- uart_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module uart_fifo
    import uart_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        push,
    input  wire data_t push_data,
    input  wire        pop,
    output data_t      head,
    output logic       empty,
    output logic       full
);

    data_t                mem [FIFO_DEPTH];
    logic [FIFO_ADDR_W:0] wr_ptr;
    logic [FIFO_ADDR_W:0] rd_ptr;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[FIFO_ADDR_W-1:0]] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assign head  = mem[rd_ptr[FIFO_ADDR_W-1:0]];
    assign empty = (wr_ptr == rd_ptr);
    // Same slot but a lap apart means every entry is occupied.
    assign full  = (wr_ptr[FIFO_ADDR_W-1:0] == rd_ptr[FIFO_ADDR_W-1:0]) &&
                   (wr_ptr[FIFO_ADDR_W] != rd_ptr[FIFO_ADDR_W]);

endmodule

`default_nettype wire

//--- uart_pkg.sv
`default_nettype none

package uart_pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  data_t;
    typedef logic [3:0]  addr_t;
    typedef logic [4:0]  bit_cnt_t;

    localparam int MAX_FRAME_BITS = 12;
    typedef logic [MAX_FRAME_BITS-1:0] frame_t;

    // Must be a power of two.
    localparam int FIFO_DEPTH  = 8;
    localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);

    localparam int    CLOCK_HZ       = 50_000_000;
    localparam int    RESET_BAUD     = 115200;
    localparam word_t BAUD_DIV_RESET = CLOCK_HZ / RESET_BAUD;

    localparam addr_t ADDR_DATA       = 4'd0;
    localparam addr_t ADDR_STATUS     = 4'd1;
    localparam addr_t ADDR_CTRL       = 4'd2;
    localparam addr_t ADDR_BAUD       = 4'd3;
    localparam addr_t ADDR_IRQ_EN     = 4'd4;
    localparam addr_t ADDR_IRQ_STATUS = 4'd5;
    localparam addr_t ADDR_RS485      = 4'd6;

    localparam int CTRL_ENABLE     = 0;
    localparam int CTRL_PARITY_EN  = 1;
    localparam int CTRL_PARITY_ODD = 2;
    localparam int CTRL_TWO_STOP   = 3;

    localparam int ST_RX_AVAIL   = 0;
    localparam int ST_TX_SPACE   = 1;
    localparam int ST_FRAME_ERR  = 2;
    localparam int ST_OVERRUN    = 3;
    localparam int ST_TX_BUSY    = 4;
    localparam int ST_PARITY_ERR = 5;

    localparam int IRQ_RX_DATA = 0;
    localparam int IRQ_TX_DONE = 1;
    localparam int IRQ_RX_ERR  = 2;

    localparam int RS_AUTO   = 0;
    localparam int RS_DE_INV = 1;
    localparam int RS_RE_INV = 2;
    localparam int RS_DE_MAN = 3;
    localparam int RS_RE_MAN = 4;

    localparam word_t CTRL_RESET  = 32'd1;
    localparam word_t RS485_RESET = 32'd1;

    typedef struct packed {
        logic  enable;
        logic  parity_en;
        logic  parity_odd;
        logic  two_stop;
        word_t baud_div;
    } line_cfg_t;

    typedef struct packed {
        logic  valid;
        data_t data;
        logic  frame_err;
        logic  parity_err;
    } rx_result_t;

    typedef enum logic {TX_IDLE, TX_SHIFT} tx_state_t;
    typedef enum logic {RX_IDLE, RX_FRAME} rx_state_t;

    // Start, eight data bits, optional parity and one or two stop bits.
    function automatic bit_cnt_t frame_bits(input logic parity_en, input logic two_stop);
        return 5'd10 + {4'd0, parity_en} + {4'd0, two_stop};
    endfunction

    function automatic logic parity_of(input data_t data, input logic odd);
        return (^data) ^ odd;
    endfunction

endpackage

`default_nettype wire

//--- uart_regs.sv
`timescale 1ns/1ns
`default_nettype none

module uart_regs
    import uart_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire             bus_write,
    input  wire             bus_read,
    input  wire addr_t      addr_word,
    input  wire word_t      wdata,
    output word_t           rdata,
    output line_cfg_t       cfg,
    output logic            tx_push,
    output data_t           tx_push_data,
    input  wire             tx_empty,
    input  wire             tx_full,
    input  wire             tx_busy,
    input  wire             tx_done,
    input  wire rx_result_t rx_result,
    output logic            rx_push,
    output logic            rx_pop,
    input  wire data_t      rx_head,
    input  wire             rx_empty,
    input  wire             rx_full,
    output logic            irq,
    output logic            rs485_de,
    output logic            rs485_re
);

    word_t ctrl;
    word_t baud_div;
    word_t irq_en;
    word_t irq_status;
    word_t rs485_ctrl;
    word_t status;
    logic  frame_err_st;
    logic  parity_err_st;
    logic  overrun_st;
    logic  data_wr;
    logic  irq_wr;
    logic  de_raw;
    logic  re_raw;

    assign data_wr      = bus_write && (addr_word == ADDR_DATA);
    assign irq_wr       = bus_write && (addr_word == ADDR_IRQ_STATUS);
    assign tx_push      = data_wr && !tx_full;
    assign tx_push_data = wdata[7:0];
    assign rx_pop       = bus_read && (addr_word == ADDR_DATA) && !rx_empty;
    assign rx_push      = rx_result.valid && !rx_result.frame_err &&
                          !rx_result.parity_err && !rx_full;

    assign cfg = '{enable:     ctrl[CTRL_ENABLE],
                   parity_en:  ctrl[CTRL_PARITY_EN],
                   parity_odd: ctrl[CTRL_PARITY_ODD],
                   two_stop:   ctrl[CTRL_TWO_STOP],
                   baud_div:   baud_div};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl       <= CTRL_RESET;
            baud_div   <= BAUD_DIV_RESET;
            irq_en     <= '0;
            rs485_ctrl <= RS485_RESET;
        end else if (bus_write) begin
            case (addr_word)
                ADDR_CTRL:   ctrl <= wdata;
                ADDR_BAUD:   baud_div <= wdata;
                ADDR_IRQ_EN: irq_en <= wdata;
                ADDR_RS485:  rs485_ctrl <= wdata;
                default:     ;
            endcase
        end
    end

    // Event sets come after the clears so a new event is never lost.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_status    <= '0;
            frame_err_st  <= 1'b0;
            parity_err_st <= 1'b0;
            overrun_st    <= 1'b0;
        end else begin
            if (irq_wr) begin
                irq_status <= irq_status & ~wdata;
                if (wdata[IRQ_RX_ERR]) begin
                    frame_err_st  <= 1'b0;
                    parity_err_st <= 1'b0;
                    overrun_st    <= 1'b0;
                end
            end
            // The data flag drops once reads have drained the FIFO.
            if (rx_empty && !rx_push) begin
                irq_status[IRQ_RX_DATA] <= 1'b0;
            end
            if (tx_done && tx_empty) begin
                irq_status[IRQ_TX_DONE] <= 1'b1;
            end
            if (data_wr) begin
                irq_status[IRQ_TX_DONE] <= 1'b0;
            end
            if (rx_result.valid) begin
                if (rx_result.frame_err) begin
                    frame_err_st           <= 1'b1;
                    irq_status[IRQ_RX_ERR] <= 1'b1;
                end else if (rx_result.parity_err) begin
                    parity_err_st          <= 1'b1;
                    irq_status[IRQ_RX_ERR] <= 1'b1;
                end else if (rx_full) begin
                    overrun_st             <= 1'b1;
                    irq_status[IRQ_RX_ERR] <= 1'b1;
                end else begin
                    irq_status[IRQ_RX_DATA] <= 1'b1;
                end
            end
        end
    end

    assign irq = |(irq_en & irq_status);

    always_comb begin
        status                = '0;
        status[ST_RX_AVAIL]   = !rx_empty;
        status[ST_TX_SPACE]   = !tx_full;
        status[ST_FRAME_ERR]  = frame_err_st;
        status[ST_OVERRUN]    = overrun_st;
        status[ST_TX_BUSY]    = tx_busy;
        status[ST_PARITY_ERR] = parity_err_st;
    end

    always_comb begin
        rdata = '0;
        if (bus_read) begin
            case (addr_word)
                ADDR_DATA:       rdata = rx_empty ? '0 : {24'd0, rx_head};
                ADDR_STATUS:     rdata = status;
                ADDR_CTRL:       rdata = ctrl;
                ADDR_BAUD:       rdata = baud_div;
                ADDR_IRQ_EN:     rdata = irq_en;
                ADDR_IRQ_STATUS: rdata = irq_status;
                ADDR_RS485:      rdata = rs485_ctrl;
                default:         rdata = '0;
            endcase
        end
    end

    // In auto mode the driver stays on while anything is queued or shifting.
    always_comb begin
        if (rs485_ctrl[RS_AUTO]) begin
            de_raw = tx_busy || !tx_empty;
            re_raw = !de_raw;
        end else begin
            de_raw = rs485_ctrl[RS_DE_MAN];
            re_raw = rs485_ctrl[RS_RE_MAN];
        end
        rs485_de = de_raw ^ rs485_ctrl[RS_DE_INV];
        rs485_re = re_raw ^ rs485_ctrl[RS_RE_INV];
    end

endmodule

`default_nettype wire

//--- uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx
    import uart_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire line_cfg_t cfg,
    input  wire            rx,
    output rx_result_t     rx_result
);

    logic      rx_meta;
    logic      rx_sync;
    rx_state_t state;
    word_t     bit_div;
    word_t     baud_cnt;
    bit_cnt_t  bit_idx;
    bit_cnt_t  last_idx;
    logic      par_en;
    logic      par_odd;
    logic      par_bit;
    data_t     data;
    logic      start_err;
    logic      stop_err;
    logic      start_det;
    logic      sample;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    assign start_det = (state == RX_IDLE) && cfg.enable && !rx_sync;
    assign sample    = (state == RX_FRAME) && (baud_cnt == bit_div);

    // Line settings are captured at the falling edge and hold for the frame.
    always_ff @(posedge clk) begin
        if (start_det) begin
            bit_div  <= cfg.baud_div;
            last_idx <= frame_bits(cfg.parity_en, cfg.two_stop) - 1'b1;
            par_en   <= cfg.parity_en;
            par_odd  <= cfg.parity_odd;
        end
        if (sample) begin
            if (bit_idx >= 5'd1 && bit_idx <= 5'd8) begin
                data <= {rx_sync, data[7:1]};
            end
            if (par_en && bit_idx == 5'd9) begin
                par_bit <= rx_sync;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= RX_IDLE;
            baud_cnt  <= '0;
            bit_idx   <= '0;
            start_err <= 1'b0;
            stop_err  <= 1'b0;
            rx_result <= '0;
        end else begin
            rx_result.valid <= 1'b0;
            if (!cfg.enable) begin
                state <= RX_IDLE;
            end else if (start_det) begin
                state <= RX_FRAME;
                // Starting half way lands every sample in the middle of a bit.
                baud_cnt  <= cfg.baud_div >> 1;
                bit_idx   <= '0;
                start_err <= 1'b0;
                stop_err  <= 1'b0;
            end else if (state == RX_FRAME) begin
                if (sample) begin
                    baud_cnt <= '0;
                    bit_idx  <= bit_idx + 1'b1;
                    if (bit_idx == 5'd0) begin
                        start_err <= rx_sync;
                    end else if (bit_idx > 5'd8 && !(par_en && bit_idx == 5'd9)) begin
                        stop_err <= stop_err | !rx_sync;
                    end
                    // The final sample is always a stop bit, so it is
                    // folded into the frame error directly.
                    if (bit_idx == last_idx) begin
                        state                <= RX_IDLE;
                        rx_result.valid      <= 1'b1;
                        rx_result.data       <= data;
                        rx_result.frame_err  <= start_err | stop_err | !rx_sync;
                        rx_result.parity_err <= par_en &&
                                                (par_bit != parity_of(data, par_odd));
                    end
                end else begin
                    baud_cnt <= baud_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- uart_top.sv
`timescale 1ns/1ns
`default_nettype none

module uart_top
    import uart_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        bus_write,
    input  wire        bus_read,
    input  wire addr_t addr_word,
    input  wire word_t wdata,
    output word_t      rdata,
    output logic       tx,
    input  wire        rx,
    output logic       rs485_de,
    output logic       rs485_re,
    output logic       irq
);

    line_cfg_t  cfg;
    logic       tx_push;
    data_t      tx_push_data;
    logic       tx_pop;
    data_t      tx_head;
    logic       tx_empty;
    logic       tx_full;
    logic       tx_busy;
    logic       tx_done;
    rx_result_t rx_result;
    logic       rx_push;
    logic       rx_pop;
    data_t      rx_head;
    logic       rx_empty;
    logic       rx_full;

    uart_regs i_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus_write    (bus_write),
        .bus_read     (bus_read),
        .addr_word    (addr_word),
        .wdata        (wdata),
        .rdata        (rdata),
        .cfg          (cfg),
        .tx_push      (tx_push),
        .tx_push_data (tx_push_data),
        .tx_empty     (tx_empty),
        .tx_full      (tx_full),
        .tx_busy      (tx_busy),
        .tx_done      (tx_done),
        .rx_result    (rx_result),
        .rx_push      (rx_push),
        .rx_pop       (rx_pop),
        .rx_head      (rx_head),
        .rx_empty     (rx_empty),
        .rx_full      (rx_full),
        .irq          (irq),
        .rs485_de     (rs485_de),
        .rs485_re     (rs485_re)
    );

    uart_fifo tx_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (tx_push),
        .push_data (tx_push_data),
        .pop       (tx_pop),
        .head      (tx_head),
        .empty     (tx_empty),
        .full      (tx_full)
    );

    uart_fifo rx_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (rx_push),
        .push_data (rx_result.data),
        .pop       (rx_pop),
        .head      (rx_head),
        .empty     (rx_empty),
        .full      (rx_full)
    );

    uart_tx i_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .fifo_empty (tx_empty),
        .fifo_head  (tx_head),
        .tx_pop     (tx_pop),
        .tx         (tx),
        .tx_busy    (tx_busy),
        .tx_done    (tx_done)
    );

    uart_rx i_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .rx        (rx),
        .rx_result (rx_result)
    );

endmodule

`default_nettype wire

//--- uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx
    import uart_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire line_cfg_t cfg,
    input  wire            fifo_empty,
    input  wire data_t     fifo_head,
    output logic           tx_pop,
    output logic           tx,
    output logic           tx_busy,
    output logic           tx_done
);

    tx_state_t state;
    frame_t    new_frame;
    frame_t    shift;
    bit_cnt_t  bits_left;
    word_t     bit_div;
    word_t     baud_cnt;
    logic      shift_now;

    // Unused high bits stay at 1 so they read as stop bits.
    always_comb begin
        new_frame      = '1;
        new_frame[0]   = 1'b0;
        new_frame[8:1] = fifo_head;
        if (cfg.parity_en) begin
            new_frame[9] = parity_of(fifo_head, cfg.parity_odd);
        end
    end

    assign tx_pop    = (state == TX_IDLE) && cfg.enable && !fifo_empty;
    assign shift_now = (state == TX_SHIFT) && (baud_cnt == bit_div);
    assign tx_busy   = (state == TX_SHIFT);

    always_ff @(posedge clk) begin
        if (tx_pop) begin
            shift   <= new_frame;
            bit_div <= cfg.baud_div;
        end else if (shift_now) begin
            shift <= {1'b1, shift[MAX_FRAME_BITS-1:1]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= TX_IDLE;
            tx        <= 1'b1;
            bits_left <= '0;
            baud_cnt  <= '0;
            tx_done   <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            if (!cfg.enable) begin
                state <= TX_IDLE;
                tx    <= 1'b1;
            end else if (tx_pop) begin
                state     <= TX_SHIFT;
                bits_left <= frame_bits(cfg.parity_en, cfg.two_stop);
                baud_cnt  <= '0;
            end else if (state == TX_SHIFT) begin
                if (shift_now) begin
                    baud_cnt  <= '0;
                    tx        <= shift[0];
                    bits_left <= bits_left - 1'b1;
                    // The last stop bit is on the line, so the next frame
                    // may load now and still leave it a full bit time.
                    if (bits_left == 5'd1) begin
                        state   <= TX_IDLE;
                        tx_done <= 1'b1;
                    end
                end else begin
                    baud_cnt <= baud_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire
